//--- Makefile
TOP := tb_leaf_i6o3

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module leaf_i6o3
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "Simulation FAILED"; \
		exit 1; \
	fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- project.f
+incdir+src
src/bft_pkg.sv
src/leaf_stream_if.sv
src/leaf_rx_demux.sv
src/leaf_in_fifo.sv
src/leaf_tx_arbiter.sv
src/leaf_interface.sv
src/user_kernel_add.sv
src/leaf_i6o3.sv
testbench/tb_leaf_i6o3.sv

//--- src/bft_pkg.sv
`include "leaf_params.svh"

package bft_pkg;

    localparam int OUT_SEL_BITS  = 2;
    localparam int BODY_BITS     = `ADDR_BITS + `PAYLOAD_BITS;
    localparam int CFG_RSVD_BITS = BODY_BITS - OUT_SEL_BITS - `LEAF_BITS - `PORT_BITS;

    // Valid bit sits at the top of the packet
    typedef struct packed {
        logic                  vld;
        logic [`LEAF_BITS-1:0] leaf;
        logic [`PORT_BITS-1:0] port;
    } pkt_hdr_t;

    typedef struct packed {
        logic [`ADDR_BITS-1:0]    addr;
        logic [`PAYLOAD_BITS-1:0] payload;
    } data_body_t;

    typedef struct packed {
        logic [OUT_SEL_BITS-1:0]  out_sel;
        logic [`LEAF_BITS-1:0]    route_leaf;
        logic [`PORT_BITS-1:0]    route_port;
        logic [CFG_RSVD_BITS-1:0] rsvd;
    } cfg_body_t;

    // Port field 0 selects cfg, ports 1..NUM_IN select data
    typedef union packed {
        data_body_t data;
        cfg_body_t  cfg;
    } pkt_body_u;

    typedef struct packed {
        pkt_hdr_t  hdr;
        pkt_body_u body;
    } bft_pkt_t;

    typedef struct packed {
        logic [`LEAF_BITS-1:0] leaf;
        logic [`PORT_BITS-1:0] port;
    } route_t;

endpackage

//--- src/leaf_i6o3.sv
`timescale 1ns/1ps
`include "leaf_params.svh"

module leaf_i6o3 (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`PACKET_BITS-1:0] din,
    input  logic                    resend,
    input  logic                    ap_start,
    output logic [`PACKET_BITS-1:0] dout
);

    logic kernel_rst;

    leaf_stream_if user_in  [`NUM_IN] ();
    leaf_stream_if user_out [`NUM_OUT] ();

    leaf_interface leaf_interface_inst (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .resend     (resend),
        .ap_start   (ap_start),
        .dout       (dout),
        .kernel_rst (kernel_rst),
        .user_in    (user_in),
        .user_out   (user_out)
    );

    // Kernel waits in reset for ap_start
    user_kernel_add user_kernel_inst (
        .clk   (clk),
        .rst   (kernel_rst),
        .in_s  (user_in),
        .out_s (user_out)
    );

endmodule

//--- src/leaf_in_fifo.sv
`timescale 1ns/1ps
`include "leaf_params.svh"

module leaf_in_fifo (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr,
    input  logic [`PAYLOAD_BITS-1:0] wdata,
    output logic                     full,
    leaf_stream_if.source            out_s
);

    localparam int PTR_BITS = $clog2(`IN_FIFO_DEPTH);

    logic [`PAYLOAD_BITS-1:0] mem [`IN_FIFO_DEPTH];
    logic [PTR_BITS-1:0]      wr_ptr_q;
    logic [PTR_BITS-1:0]      rd_ptr_q;
    logic [PTR_BITS:0]        count_q;
    logic                     push;
    logic                     pop;

    assign full = (count_q == (PTR_BITS+1)'(`IN_FIFO_DEPTH));
    // Writes into a full buffer are lost
    assign push = wr && !full;
    assign pop  = out_s.vld && out_s.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_BITS'(`IN_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_BITS'(`IN_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= wdata;
        end
    end

    assign out_s.data      = mem[rd_ptr_q];
    assign out_s.vld       = (count_q != '0);
    assign out_s.last_pair = 1'b0;

    assert property (@(posedge clk) disable iff (rst) count_q <= `IN_FIFO_DEPTH)
        else $error("input FIFO count past depth");

endmodule

//--- src/leaf_interface.sv
`timescale 1ns/1ps
`include "leaf_params.svh"

module leaf_interface import bft_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  bft_pkt_t      din,
    input  logic          resend,
    input  logic          ap_start,
    output bft_pkt_t      dout,
    output logic          kernel_rst,
    leaf_stream_if.source user_in  [`NUM_IN],
    leaf_stream_if.sink   user_out [`NUM_OUT]
);

    logic [`NUM_IN-1:0]       fifo_wr;
    logic [`PAYLOAD_BITS-1:0] fifo_wdata;
    logic                     route_wr;
    logic [OUT_SEL_BITS-1:0]  route_sel;
    route_t                   route_val;
    logic                     started_q;

    leaf_rx_demux rx_inst (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .fifo_wr    (fifo_wr),
        .fifo_wdata (fifo_wdata),
        .route_wr   (route_wr),
        .route_sel  (route_sel),
        .route_val  (route_val)
    );

    for (genvar i = 0; i < `NUM_IN; i++) begin : g_in
        leaf_in_fifo fifo_inst (
            .clk   (clk),
            .rst   (rst),
            .wr    (fifo_wr[i]),
            .wdata (fifo_wdata),
            .full  (),
            .out_s (user_in[i])
        );
    end

    leaf_tx_arbiter tx_inst (
        .clk       (clk),
        .rst       (rst),
        .resend    (resend),
        .route_wr  (route_wr),
        .route_sel (route_sel),
        .route_val (route_val),
        .dout      (dout),
        .res_s     (user_out)
    );

    // Sticky until the next reset
    always_ff @(posedge clk) begin
        if (rst) begin
            started_q <= 1'b0;
        end else if (ap_start) begin
            started_q <= 1'b1;
        end
    end

    assign kernel_rst = !started_q;

endmodule

//--- src/leaf_params.svh
`ifndef LEAF_PARAMS_SVH
`define LEAF_PARAMS_SVH

// Tree packet and user word widths
`define PACKET_BITS   49
`define PAYLOAD_BITS  32

// Address fields of a tree packet
`define LEAF_BITS     5
`define PORT_BITS     4
`define ADDR_BITS     7

// This leaf's position in the tree
`define LEAF_ID       5'd6

// Port counts and buffering
`define NUM_IN        6
`define NUM_OUT       3
`define IN_FIFO_DEPTH 4

`endif

//--- src/leaf_rx_demux.sv
`timescale 1ns/1ps
`include "leaf_params.svh"

module leaf_rx_demux import bft_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  bft_pkt_t                 din,
    output logic [`NUM_IN-1:0]       fifo_wr,
    output logic [`PAYLOAD_BITS-1:0] fifo_wdata,
    output logic                     route_wr,
    output logic [OUT_SEL_BITS-1:0]  route_sel,
    output route_t                   route_val
);

    pkt_hdr_t  hdr_q;
    pkt_body_u body_q;
    logic      for_me;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_q <= '0;
        end else begin
            hdr_q <= din.hdr;
        end
    end

    always_ff @(posedge clk) begin
        body_q <= din.body;
    end

    assign for_me = hdr_q.vld && (hdr_q.leaf == `LEAF_ID);

    // Port 0 is config, 1..NUM_IN are data, anything above is discarded
    always_comb begin
        fifo_wr  = '0;
        route_wr = 1'b0;
        if (for_me) begin
            if (hdr_q.port == '0) begin
                route_wr = 1'b1;
            end
            for (int i = 0; i < `NUM_IN; i++) begin
                if (int'(hdr_q.port) == i + 1) begin
                    fifo_wr[i] = 1'b1;
                end
            end
        end
    end

    // Same body word, read through both views of the union
    assign fifo_wdata     = body_q.data.payload;
    assign route_sel      = body_q.cfg.out_sel;
    assign route_val.leaf = body_q.cfg.route_leaf;
    assign route_val.port = body_q.cfg.route_port;

    // One packet reaches at most one FIFO or the routing table
    assert property (@(posedge clk) disable iff (rst) $onehot0({fifo_wr, route_wr}))
        else $error("rx decoded one packet to several targets");

endmodule

//--- src/leaf_stream_if.sv
`timescale 1ns/1ps
`include "leaf_params.svh"

interface leaf_stream_if;

    logic [`PAYLOAD_BITS-1:0] data;
    logic                     vld;
    logic                     ack;
    // Marks a word that completes an input pair
    logic                     last_pair;

    modport source (
        output data, vld, last_pair,
        input  ack
    );

    modport sink (
        input  data, vld, last_pair,
        output ack
    );

endinterface

//--- src/leaf_tx_arbiter.sv
`timescale 1ns/1ps
`include "leaf_params.svh"

module leaf_tx_arbiter import bft_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    resend,
    input  logic                    route_wr,
    input  logic [OUT_SEL_BITS-1:0] route_sel,
    input  route_t                  route_val,
    output bft_pkt_t                dout,
    leaf_stream_if.sink             res_s [`NUM_OUT]
);

    route_t                   route_q  [`NUM_OUT];
    logic [`ADDR_BITS-1:0]    seq_q    [`NUM_OUT];
    logic [`PAYLOAD_BITS-1:0] res_data [`NUM_OUT];
    logic [`NUM_OUT-1:0]      res_vld;
    logic [`NUM_OUT-1:0]      res_ack;
    logic [OUT_SEL_BITS-1:0]  last_q;
    logic [OUT_SEL_BITS-1:0]  pend_sel_q;
    logic [OUT_SEL_BITS-1:0]  pick;
    logic                     pick_vld;
    logic                     pend_q;
    logic                     accept;
    bft_pkt_t                 pkt_q;

    for (genvar i = 0; i < `NUM_OUT; i++) begin : g_res
        assign res_vld[i]   = res_s[i].vld && res_s[i].last_pair;
        assign res_data[i]  = res_s[i].data;
        assign res_s[i].ack = res_ack[i];
    end

    // Round robin, starting just after the port served last
    always_comb begin
        int idx;
        pick_vld = 1'b0;
        pick     = '0;
        for (int off = `NUM_OUT; off >= 1; off--) begin
            idx = (int'(last_q) + off) % `NUM_OUT;
            if (res_vld[idx]) begin
                pick_vld = 1'b1;
                pick     = OUT_SEL_BITS'(idx);
            end
        end
    end

    assign accept = pick_vld && !pend_q;

    always_comb begin
        res_ack = '0;
        if (accept) begin
            res_ack[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_OUT; i++) begin
                route_q[i] <= '0;
                seq_q[i]   <= '0;
            end
            pend_q     <= 1'b0;
            pend_sel_q <= '0;
            last_q     <= OUT_SEL_BITS'(`NUM_OUT - 1);
        end else begin
            if (route_wr && (route_sel < OUT_SEL_BITS'(`NUM_OUT))) begin
                route_q[route_sel] <= route_val;
            end
            if (accept) begin
                pend_q     <= 1'b1;
                pend_sel_q <= pick;
                last_q     <= pick;
            end else if (pend_q && !resend) begin
                // Packet went out this cycle
                pend_q              <= 1'b0;
                seq_q[pend_sel_q]   <= seq_q[pend_sel_q] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pkt_q.hdr.vld           <= 1'b1;
            pkt_q.hdr.leaf          <= route_q[pick].leaf;
            pkt_q.hdr.port          <= route_q[pick].port;
            pkt_q.body.data.addr    <= seq_q[pick];
            pkt_q.body.data.payload <= res_data[pick];
        end
    end

    // Tree sees zero during resend, the packet stays put
    assign dout = (pend_q && !resend) ? pkt_q : '0;

    // A packet held by resend is not replaced by a newly acked result
    assert property (@(posedge clk) disable iff (rst)
        pend_q && resend |=> pend_q && $stable(pkt_q))
        else $error("pending packet replaced while resend held it");

endmodule

//--- src/user_kernel_add.sv
`timescale 1ns/1ps
`include "leaf_params.svh"

module user_kernel_add (
    input  logic          clk,
    input  logic          rst,
    leaf_stream_if.sink   in_s  [`NUM_IN],
    leaf_stream_if.source out_s [`NUM_OUT]
);

    // Goes high the cycle after reset releases
    logic run_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // Output k adds inputs 2k and 2k+1 (ports 2k+1 and 2k+2 on the tree)
    for (genvar k = 0; k < `NUM_OUT; k++) begin : g_pair
        logic                     fire;
        logic                     out_vld_q;
        logic [`PAYLOAD_BITS-1:0] sum_q;

        assign fire = run_q && in_s[2*k].vld && in_s[2*k+1].vld && !out_vld_q;

        assign in_s[2*k].ack   = fire;
        assign in_s[2*k+1].ack = fire;

        always_ff @(posedge clk) begin
            if (rst) begin
                out_vld_q <= 1'b0;
            end else if (fire) begin
                out_vld_q <= 1'b1;
            end else if (out_s[k].ack) begin
                out_vld_q <= 1'b0;
            end
        end

        // Wraps modulo 2^32
        always_ff @(posedge clk) begin
            if (fire) begin
                sum_q <= in_s[2*k].data + in_s[2*k+1].data;
            end
        end

        assign out_s[k].data      = sum_q;
        assign out_s[k].vld       = out_vld_q;
        assign out_s[k].last_pair = out_vld_q;
    end

endmodule

//--- testbench/tb_leaf_i6o3.sv
`timescale 1ns/1ps
`include "leaf_params.svh"

module tb_leaf_i6o3 import bft_pkg::*; ();

    localparam int NUM_BATCHES = 24;
    localparam int SEED        = 32'hc50f1c6e;
    // Each fixed phase gets the budget of one random batch
    localparam int WATCHDOG_CYCLES = (NUM_BATCHES + 3) * 2000;

    logic                    clk;
    logic                    rst;
    logic [`PACKET_BITS-1:0] din;
    logic                    resend;
    logic                    ap_start;
    logic [`PACKET_BITS-1:0] dout;

    logic resend_en;
    logic started;
    int   err_cnt;
    int   check_cnt;

    // Reference model state
    logic [`PAYLOAD_BITS-1:0] in_q  [`NUM_IN][$];
    logic [`PAYLOAD_BITS-1:0] exp_q [`NUM_OUT][$];
    route_t                   route_tbl [`NUM_OUT];
    logic [`ADDR_BITS-1:0]    seq_cnt   [`NUM_OUT];

    leaf_i6o3 leaf_i6o3_i (
        .clk      (clk),
        .rst      (rst),
        .din      (din),
        .resend   (resend),
        .ap_start (ap_start),
        .dout     (dout)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
        check_cnt++;
        if (exp !== got) begin
            err_cnt++;
            $display("error %s exp %0h got %0h", name, exp, got);
        end
    endtask

    task automatic report_failure(input string msg);
        err_cnt++;
        $display("%s", msg);
    endtask

    function automatic bft_pkt_t data_pkt(input int port, input logic [31:0] payload);
        bft_pkt_t p;
        p                   = '0;
        p.hdr.vld           = 1'b1;
        p.hdr.leaf          = `LEAF_ID;
        p.hdr.port          = `PORT_BITS'(port);
        p.body.data.payload = payload;
        return p;
    endfunction

    function automatic bft_pkt_t cfg_pkt(input int k, input route_t r);
        bft_pkt_t p;
        p                    = '0;
        p.hdr.vld            = 1'b1;
        p.hdr.leaf           = `LEAF_ID;
        p.body.cfg.out_sel   = OUT_SEL_BITS'(k);
        p.body.cfg.route_leaf = r.leaf;
        p.body.cfg.route_port = r.port;
        return p;
    endfunction

    task automatic send(input bft_pkt_t p);
        @(posedge clk);
        din <= p;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        din <= '0;
    endtask

    // A port holding DEPTH words with an empty partner is full, so the word is lost
    task automatic model_write(input int i, input logic [31:0] w);
        int                       k;
        logic [`PAYLOAD_BITS-1:0] sum;
        k = i / 2;
        if (in_q[i].size() == `IN_FIFO_DEPTH && in_q[i ^ 1].size() == 0) begin
            return;
        end
        in_q[i].push_back(w);
        if (in_q[2*k].size() != 0 && in_q[2*k+1].size() != 0) begin
            sum = in_q[2*k].pop_front() + in_q[2*k+1].pop_front();
            exp_q[k].push_back(sum);
        end
    endtask

    task automatic write_word(input int i, input logic [31:0] w);
        send(data_pkt(i + 1, w));
        model_write(i, w);
    endtask

    // Port ranges per output keep the routes distinct
    task automatic set_routes();
        route_t r;
        for (int k = 0; k < `NUM_OUT; k++) begin
            r.leaf = `LEAF_BITS'($urandom);
            r.port = `PORT_BITS'(k * 5 + $urandom % 5);
            send(cfg_pkt(k, r));
            route_tbl[k] = r;
        end
        drive_idle();
    endtask

    task automatic send_junk();
        bft_pkt_t p;
        p = data_pkt(1 + $urandom % `NUM_IN, $urandom);
        case ($urandom % 3)
            0: p.hdr.vld = 1'b0;
            1: p.hdr.leaf = `LEAF_ID ^ `LEAF_BITS'(1 + $urandom % 31);
            default: p.hdr.port = `PORT_BITS'(7 + $urandom % 9);
        endcase
        send(p);
    endtask

    task automatic wait_drain();
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
    endtask

    task automatic run_batch();
        int left [`NUM_IN];
        int total;
        int n;
        int i;
        total = 0;
        for (int k = 0; k < `NUM_OUT; k++) begin
            n = $urandom % (`IN_FIFO_DEPTH + 1);
            left[2*k]   = n;
            left[2*k+1] = n;
            total += 2 * n;
        end
        while (total > 0) begin
            i = $urandom % `NUM_IN;
            if (left[i] > 0) begin
                if ($urandom % 4 == 0) begin
                    send_junk();
                end
                write_word(i, $urandom);
                left[i]--;
                total--;
            end
        end
        drive_idle();
        wait_drain();
    endtask

    task automatic take_packet(input bft_pkt_t p);
        int                       k;
        logic [`PAYLOAD_BITS-1:0] exp_sum;
        k = -1;
        for (int j = 0; j < `NUM_OUT; j++) begin
            if (p.hdr.leaf == route_tbl[j].leaf && p.hdr.port == route_tbl[j].port) begin
                k = j;
            end
        end
        if (!started) begin
            report_failure("a packet left the leaf before ap_start");
        end else if (k < 0) begin
            report_failure($sformatf("packet to leaf %0d port %0d matches no route",
                                     p.hdr.leaf, p.hdr.port));
        end else if (exp_q[k].size() == 0) begin
            report_failure($sformatf("extra packet for output %0d", k));
        end else begin
            exp_sum = exp_q[k].pop_front();
            check("dout.payload", exp_sum, p.body.data.payload);
            check("dout.addr", seq_cnt[k], p.body.data.addr);
            seq_cnt[k] = seq_cnt[k] + 1'b1;
        end
    endtask

    // Sampled away from the driving edge
    always @(negedge clk) begin
        if (!rst) begin
            if (resend || !dout[`PACKET_BITS-1]) begin
                check("dout", '0, dout);
            end else begin
                take_packet(dout);
            end
        end
    end

    always @(posedge clk) begin
        if (resend_en) begin
            resend <= ($urandom % 4 == 0);
        end else begin
            resend <= 1'b0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst       = 1'b1;
        din       = '0;
        resend    = 1'b0;
        ap_start  = 1'b0;
        resend_en = 1'b0;
        started   = 1'b0;
        err_cnt   = 0;
        check_cnt = 0;
        for (int k = 0; k < `NUM_OUT; k++) begin
            seq_cnt[k]   = '0;
            route_tbl[k] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        set_routes();
        // Kernel still held, words wait in the FIFOs
        for (int i = 0; i < `NUM_IN; i++) begin
            for (int n = 0; n < 2; n++) begin
                write_word(i, $urandom);
            end
        end
        drive_idle();
        repeat (50) @(posedge clk);
        ap_start <= 1'b1;
        started  <= 1'b1;
        @(posedge clk);
        ap_start <= 1'b0;
        wait_drain();

        resend_en <= 1'b1;
        for (int b = 0; b < NUM_BATCHES; b++) begin
            if (b % 4 == 0) begin
                set_routes();
            end
            run_batch();
        end

        // Port 2 left empty so port 1 fills and drops its fifth word
        for (int n = 0; n < `IN_FIFO_DEPTH + 1; n++) begin
            write_word(0, $urandom);
        end
        drive_idle();
        repeat (20) @(posedge clk);
        // A fifth word kept on port 1 would pair with the extra word on port 2
        for (int n = 0; n < `IN_FIFO_DEPTH + 1; n++) begin
            write_word(1, $urandom);
        end
        write_word(0, $urandom);
        drive_idle();
        wait_drain();

        $display("checks %0d errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
